// File: Makefile
VERILATOR ?= verilator
TOP       ?= game_ctrl_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FILELIST  := list.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
STIM      := tests/game_ctrl_stimulus.txt
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN) $(STIM)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/game_pkg.sv
package game_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // keyboard
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [9:0] key_vec_t;

    localparam int KEY_P2_UP       = 0;
    localparam int KEY_P2_LEFT     = 1;
    localparam int KEY_MENU_PREV_B = 2;
    localparam int KEY_P2_RIGHT    = 3;
    localparam int KEY_P1_UP       = 4; // doubles as menu next.
    localparam int KEY_P1_LEFT     = 5;
    localparam int KEY_MENU_PREV_A = 6;
    localparam int KEY_P1_RIGHT    = 7;
    localparam int KEY_CONFIRM     = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // menu
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [2:0] level_t;

    localparam level_t LEVEL_MIN = 3'd1;
    localparam level_t LEVEL_MAX = 3'd5;

    typedef struct packed {
        logic next;
        logic prev;
        logic confirm;
    } menu_evt_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // players
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic up;
        logic left;
        logic right;
    } move_t;

    typedef struct packed {
        logic collision;
        logic land;
        logic should_down;
    } phys_t;

    typedef enum logic [3:0] {
        POSE_STATIC = 4'd6,
        POSE_RIGHT  = 4'd7,
        POSE_LEFT   = 4'd8,
        POSE_UP     = 4'd9
    } pose_e;

    typedef enum logic [1:0] {
        JUMP_IDLE = 2'd0,
        JUMP_RISE = 2'd1,
        JUMP_FALL = 2'd2
    } jump_e;

    typedef logic [29:0] jump_cnt_t;

    typedef struct packed {
        pose_e pose;
        jump_e jump;
    } player_t;

    localparam jump_cnt_t JUMP_RISE_LIMIT = 30'd70_000_000;
    localparam jump_cnt_t JUMP_FALL_LIMIT = 30'd240_000_000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vga and menu sprite sheet
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [9:0]  pix_coord_t;
    typedef logic [16:0] pix_addr_t;

    localparam pix_coord_t MENU_ROW_TOP [1:5] = '{10'd40, 10'd80, 10'd120, 10'd160, 10'd200};
    localparam pix_coord_t MENU_ROW_H      = 10'd25;
    localparam pix_coord_t MENU_COL_X      = 10'd150;
    localparam pix_coord_t MENU_SEL_X      = 10'd148; // highlight starts two pixels early.
    localparam pix_coord_t MENU_COL_END    = 10'd170;
    localparam pix_coord_t MENU_SEL_OFFSET = 10'd127;
    localparam pix_addr_t  SHEET_W         = 17'd320;

endpackage

// File: hw/game_ctrl_top.sv
`timescale 1ns/1ps

module game_ctrl_top #(
    parameter game_pkg::jump_cnt_t RISE_LIMIT = game_pkg::JUMP_RISE_LIMIT,
    parameter game_pkg::jump_cnt_t FALL_LIMIT = game_pkg::JUMP_FALL_LIMIT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  game_pkg::key_vec_t   key_down,
    input  game_pkg::pix_coord_t vga_h,
    input  game_pkg::pix_coord_t vga_v,
    input  game_pkg::phys_t      p1_phys,
    input  game_pkg::phys_t      p2_phys,
    output game_pkg::pix_addr_t  pixel_addr,
    output logic                 flag_cover,
    output game_pkg::level_t     level,
    output logic                 playing,
    output game_pkg::player_t    p1,
    output game_pkg::player_t    p2
);
    import game_pkg::*;

    menu_evt_t menu_evt;
    move_t     p1_move;
    move_t     p2_move;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    key_decoder u_key_decoder (
        .clk      (clk),
        .rst      (rst),
        .key_down (key_down),
        .playing  (playing),
        .menu_evt (menu_evt),
        .p1_move  (p1_move),
        .p2_move  (p2_move)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // menu and players
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    menu_fsm u_menu_fsm (
        .clk      (clk),
        .rst      (rst),
        .menu_evt (menu_evt),
        .level    (level),
        .playing  (playing),
        .on_cover (flag_cover)
    );

    player_ctrl #(
        .RISE_LIMIT (RISE_LIMIT),
        .FALL_LIMIT (FALL_LIMIT)
    ) u_player1 (
        .clk     (clk),
        .rst     (rst),
        .playing (playing),
        .move    (p1_move),
        .phys    (p1_phys),
        .player  (p1)
    );

    player_ctrl #(
        .RISE_LIMIT (RISE_LIMIT),
        .FALL_LIMIT (FALL_LIMIT)
    ) u_player2 (
        .clk     (clk),
        .rst     (rst),
        .playing (playing),
        .move    (p2_move),
        .phys    (p2_phys),
        .player  (p2)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    menu_addr_gen u_menu_addr_gen (
        .clk        (clk),
        .rst        (rst),
        .vga_h      (vga_h),
        .vga_v      (vga_v),
        .level      (level),
        .playing    (playing),
        .on_cover   (flag_cover),
        .pixel_addr (pixel_addr)
    );

endmodule

// File: hw/key_decoder.sv
`timescale 1ns/1ps

module key_decoder (
    input  logic               clk,
    input  logic               rst,
    input  game_pkg::key_vec_t key_down,
    input  logic               playing,
    output game_pkg::menu_evt_t menu_evt,
    output game_pkg::move_t    p1_move,
    output game_pkg::move_t    p2_move
);
    import game_pkg::*;

    logic armed; // cleared after next/prev until all keys are up.
    logic next_key;
    logic prev_key;

    assign next_key = key_down[KEY_P2_UP] | key_down[KEY_P1_UP];
    assign prev_key = key_down[KEY_MENU_PREV_B] | key_down[KEY_MENU_PREV_A];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // menu events
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed    <= 1'b1;
            menu_evt <= '0;
        end else begin
            menu_evt <= '0; // single-cycle pulses.
            if (key_down == '0) begin
                armed <= 1'b1;
            end else if (armed && !playing) begin
                if (next_key) begin
                    menu_evt.next <= 1'b1;
                    armed         <= 1'b0;
                end else if (prev_key) begin
                    menu_evt.prev <= 1'b1;
                    armed         <= 1'b0;
                end else if (key_down[KEY_CONFIRM]) begin
                    menu_evt.confirm <= 1'b1; // held confirm repeats.
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // move intents
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        p1_move = '0;
        p2_move = '0;
        if (playing) begin
            p1_move.up    = key_down[KEY_P1_UP];
            p1_move.left  = key_down[KEY_P1_LEFT];
            p1_move.right = key_down[KEY_P1_RIGHT];
            p2_move.up    = key_down[KEY_P2_UP];
            p2_move.left  = key_down[KEY_P2_LEFT];
            p2_move.right = key_down[KEY_P2_RIGHT];
        end
    end

endmodule

// File: hw/menu_addr_gen.sv
`timescale 1ns/1ps

module menu_addr_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  game_pkg::pix_coord_t vga_h,
    input  game_pkg::pix_coord_t vga_v,
    input  game_pkg::level_t     level,
    input  logic                 playing,
    input  logic                 on_cover,
    output game_pkg::pix_addr_t  pixel_addr
);
    import game_pkg::*;

    pix_coord_t h_half;
    pix_coord_t v_half;
    pix_addr_t  addr_nxt;
    pix_addr_t  addr_q;

    // sprite sheet is drawn at half resolution.
    assign h_half = vga_h >> 1;
    assign v_half = vga_v >> 1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pix_coord_t top;
        pix_addr_t  line_base;
        addr_nxt = '0;
        for (int k = 1; k <= 5; k++) begin
            top       = MENU_ROW_TOP[k];
            line_base = pix_addr_t'(v_half - top + 10'd1) * SHEET_W;
            if (v_half >= top && v_half < top + MENU_ROW_H) begin
                if (level == level_t'(k)) begin
                    // chosen row reads the highlighted copy.
                    if (h_half >= MENU_SEL_X && h_half < MENU_COL_END) begin
                        addr_nxt = pix_addr_t'(h_half - MENU_SEL_OFFSET) + line_base;
                    end
                end else if (h_half >= MENU_COL_X && h_half < MENU_COL_END) begin
                    addr_nxt = pix_addr_t'(h_half - MENU_COL_X) + line_base;
                end
            end
        end
        if (playing || on_cover) begin
            addr_nxt = '0; // menu not on screen.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr_q <= '0;
        end else begin
            addr_q <= addr_nxt;
        end
    end

    assign pixel_addr = addr_q;

endmodule

// File: hw/menu_fsm.sv
`timescale 1ns/1ps

module menu_fsm (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::menu_evt_t menu_evt,
    output game_pkg::level_t    level,
    output logic                playing,
    output logic                on_cover
);
    import game_pkg::*;

    level_t level_q;
    logic   playing_q;
    logic   cover_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // level select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level_q <= LEVEL_MIN;
        end else if (menu_evt.next) begin
            if (level_q < LEVEL_MAX) begin
                level_q <= level_q + 3'd1;
            end
        end else if (menu_evt.prev) begin
            if (level_q > LEVEL_MIN) begin
                level_q <= level_q - 3'd1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cover and play mode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cover_q   <= 1'b1;
            playing_q <= 1'b0;
        end else if (menu_evt.confirm) begin
            if (cover_q) begin
                cover_q <= 1'b0; // first confirm leaves the title.
            end else begin
                playing_q <= 1'b1; // sticky until reset.
            end
        end
    end

    assign level    = level_q;
    assign playing  = playing_q;
    assign on_cover = cover_q;

endmodule

// File: list.f
common/game_pkg.sv
hw/key_decoder.sv
hw/menu_fsm.sv
player/player_ctrl.sv
hw/menu_addr_gen.sv
hw/game_ctrl_top.sv
tests/game_ctrl_tb.sv

// File: player/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl #(
    parameter game_pkg::jump_cnt_t RISE_LIMIT = game_pkg::JUMP_RISE_LIMIT,
    parameter game_pkg::jump_cnt_t FALL_LIMIT = game_pkg::JUMP_FALL_LIMIT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              playing,
    input  game_pkg::move_t   move,
    input  game_pkg::phys_t   phys,
    output game_pkg::player_t player
);
    import game_pkg::*;

    player_t   state_q;
    player_t   state_nxt;
    jump_cnt_t cnt_q;
    jump_cnt_t cnt_nxt;

    jump_e     step_jump;
    jump_cnt_t step_cnt;
    jump_e     fall_jump;
    jump_cnt_t fall_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // jump phase steps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fall part only.
    always_comb begin
        if (cnt_q < FALL_LIMIT && !phys.land) begin
            fall_jump = JUMP_FALL;
            fall_cnt  = cnt_q + 1'b1;
        end else begin
            fall_jump = JUMP_IDLE; // landed or timed out.
            fall_cnt  = '0;
        end
    end

    // full step: rise until limit or head hit, then fall.
    always_comb begin
        if (cnt_q < RISE_LIMIT && !phys.collision && state_q.jump != JUMP_FALL) begin
            step_jump = JUMP_RISE;
            step_cnt  = cnt_q + 1'b1;
        end else begin
            step_jump = fall_jump;
            step_cnt  = fall_cnt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pose and next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_nxt = state_q;
        cnt_nxt   = cnt_q;
        if (!move.up && !move.left && !move.right) begin
            if (state_q.jump == JUMP_IDLE) begin
                state_nxt.pose = POSE_STATIC;
                cnt_nxt        = '0;
            end else begin
                state_nxt.jump = step_jump; // finish the airborne phase.
                cnt_nxt        = step_cnt;
            end
        end else if (move.up && !move.left && !move.right) begin
            state_nxt.pose = POSE_UP;
            state_nxt.jump = step_jump;
            cnt_nxt        = step_cnt;
        end else if (move.left != move.right) begin
            if (move.left) begin
                state_nxt.pose = POSE_LEFT;
            end else begin
                state_nxt.pose = POSE_RIGHT;
            end
            if ((move.up || state_q.jump != JUMP_IDLE) && !phys.should_down) begin
                state_nxt.jump = step_jump;
                cnt_nxt        = step_cnt;
            end else if (phys.should_down) begin
                state_nxt.jump = fall_jump; // walked off an edge.
                cnt_nxt        = fall_cnt;
            end else begin
                state_nxt.jump = JUMP_IDLE;
            end
        end else if (state_q.jump != JUMP_IDLE) begin
            state_nxt.jump = step_jump; // both sides held, pose kept.
            cnt_nxt        = step_cnt;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q.pose <= POSE_STATIC;
            state_q.jump <= JUMP_IDLE;
            cnt_q        <= '0;
        end else if (!playing) begin
            state_q.pose <= POSE_STATIC; // held in reset outside play.
            state_q.jump <= JUMP_IDLE;
            cnt_q        <= '0;
        end else begin
            state_q <= state_nxt;
            cnt_q   <= cnt_nxt;
        end
    end

    assign player = state_q;

endmodule

// File: tests/game_ctrl_stimulus.txt
# op  a   b   n  cover level playing p1 p2 pixel_addr   (all values hex, n decimal-safe hex)
# key a=key_down; phys a=p1_phys b=p2_phys; pix a=vga_h b=vga_v n=random coords; else n=cycles
wait 0   0   1  1 1 0 18 18 0
pix  0   0   4  1 1 0 18 18 0
key  100 0   0  1 1 0 18 18 0
key  0   0   2  0 1 0 18 18 0
key  40  0   3  0 1 0 18 18 0
key  0   0   1  0 1 0 18 18 0
key  10  0   9  0 2 0 18 18 0
key  0   0   1  0 2 0 18 18 0
key  1   0   0  0 2 0 18 18 0
key  0   0   2  0 3 0 18 18 0
key  10  0   0  0 3 0 18 18 0
key  0   0   2  0 4 0 18 18 0
key  10  0   0  0 4 0 18 18 0
key  0   0   2  0 5 0 18 18 0
key  1   0   0  0 5 0 18 18 0
key  0   0   2  0 5 0 18 18 0
key  40  0   0  0 5 0 18 18 0
key  0   0   2  0 4 0 18 18 0
key  4   0   0  0 4 0 18 18 0
key  0   0   2  0 3 0 18 18 0
pix  128 f0  0  0 3 0 18 18 155
pix  153 113 0  0 3 0 18 18 16aa
pix  154 f0  0  0 3 0 18 18 0
pix  12c 81  0  0 3 0 18 18 1f40
pix  12c 82  0  0 3 0 18 18 0
pix  128 50  0  0 3 0 18 18 0
pix  153 191 8  0 3 0 18 18 153
pix  0   0   0  0 3 0 18 18 0
key  100 0   0  0 3 0 18 18 0
key  0   0   2  0 3 1 18 18 0
pix  12c 50  4  0 3 1 18 18 0
key  40  0   2  0 3 1 18 18 0
key  10  0   1  0 3 1 25 18 0
wait 0   0   2  0 3 1 25 18 0
wait 0   0   0  0 3 1 26 18 0
wait 0   0   4  0 3 1 26 18 0
key  0   0   0  0 3 1 24 18 0
wait 0   0   0  0 3 1 18 18 0
key  10  0   1  0 3 1 25 18 0
phys 4   0   0  0 3 1 25 18 0
wait 0   0   0  0 3 1 26 18 0
phys 2   0   1  0 3 1 24 18 0
key  0   0   0  0 3 1 25 18 0
phys 0   0   0  0 3 1 25 18 0
wait 0   0   9  0 3 1 18 18 0
key  21  0   1  0 3 1 20 25 0
key  80  0   0  0 3 1 20 25 0
wait 0   0   0  0 3 1 1c 25 0
phys 1   0   0  0 3 1 1c 25 0
wait 0   0   0  0 3 1 1e 26 0
key  a0  0   0  0 3 1 1e 26 0
phys 0   0   0  0 3 1 1e 26 0
key  0   0   0  0 3 1 1e 26 0
wait 0   0   8  0 3 1 18 18 0

// File: tests/game_ctrl_tb.sv
`timescale 1ns/1ps

module game_ctrl_tb;
    import game_pkg::*;

    localparam int    CLK_HALF    = 50;
    localparam int    CYC_PER_VEC = 20;
    localparam int    CYC_MARGIN  = 100;
    localparam string STIM_FILE   = "tests/game_ctrl_stimulus.txt";

    typedef enum logic [1:0] {OP_KEY, OP_PHYS, OP_PIX, OP_WAIT} op_e;

    typedef struct packed {
        op_e        op;
        logic [9:0] a;
        logic [9:0] b;
        logic [7:0] n;
        logic       cover_flag;
        level_t     level;
        logic       playing;
        player_t    p1;
        player_t    p2;
        pix_addr_t  addr;
    } vec_t;

    logic       clk;
    logic       rst;
    key_vec_t   key_down;
    pix_coord_t vga_h;
    pix_coord_t vga_v;
    phys_t      p1_phys;
    phys_t      p2_phys;
    pix_addr_t  pixel_addr;
    logic       flag_cover;
    level_t     level;
    logic       playing;
    player_t    p1;
    player_t    p2;

    vec_t vecs[$];
    int   vec_idx;
    bit   loaded;

    game_ctrl_top #(
        .RISE_LIMIT (30'd4),
        .FALL_LIMIT (30'd10)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .key_down   (key_down),
        .vga_h      (vga_h),
        .vga_v      (vga_v),
        .p1_phys    (p1_phys),
        .p2_phys    (p2_phys),
        .pixel_addr (pixel_addr),
        .flag_cover (flag_cover),
        .level      (level),
        .playing    (playing),
        .p1         (p1),
        .p2         (p2)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk; // 100 ns period.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_level(input string name, input level_t got, input level_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h (vector %0d)",
                                     name, got, exp, vec_idx));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h (vector %0d)",
                                     name, got, exp, vec_idx));
        end
    endtask

    task automatic check_player(input string name, input player_t got, input player_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h (vector %0d)",
                                     name, got, exp, vec_idx));
        end
    endtask

    task automatic check_addr(input string name, input pix_addr_t got, input pix_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h (vector %0d)",
                                     name, got, exp, vec_idx));
        end
    endtask

    // menu rows start every 40 halved lines from line 40, each 25 lines tall.
    function automatic pix_addr_t expected_addr(input pix_coord_t h, input pix_coord_t v,
                                                input level_t lvl, input logic in_play,
                                                input logic on_cover);
        int hh;
        int vh;
        int row;
        int row_line;
        int col_lo;
        int col_off;
        hh = int'(h) / 2;
        vh = int'(v) / 2;
        if (in_play || on_cover || vh < 40) begin
            return '0;
        end
        row      = (vh - 40) / 40 + 1;
        row_line = (vh - 40) % 40;
        if (row > 5 || row_line >= 25) begin
            return '0;
        end
        col_lo  = (row == int'(lvl)) ? 148 : 150; // chosen row is highlighted.
        col_off = (row == int'(lvl)) ? 127 : 150;
        if (hh < col_lo || hh >= 170) begin
            return '0;
        end
        return pix_addr_t'((hh - col_off) + (row_line + 1) * 320);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic load_vectors();
        int    fd;
        int    cnt;
        int    a;
        int    b;
        int    n;
        int    cov;
        int    lvl;
        int    ply;
        int    e1;
        int    e2;
        int    ea;
        string op;
        string rest;
        vec_t  v;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_failure({"could not open ", STIM_FILE});
        end
        while (!$feof(fd)) begin
            cnt = $fscanf(fd, "%s", op);
            if (cnt != 1) begin
                break;
            end
            if (op.getc(0) == "#") begin
                cnt = $fgets(rest, fd); // comment line.
                continue;
            end
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", a, b, n, cov, lvl, ply, e1, e2, ea);
            if (cnt != 9) begin
                report_failure($sformatf("stimulus line %0d is incomplete", vecs.size()));
            end
            if (op == "key") begin
                v.op = OP_KEY;
            end else if (op == "phys") begin
                v.op = OP_PHYS;
            end else if (op == "pix") begin
                v.op = OP_PIX;
            end else if (op == "wait") begin
                v.op = OP_WAIT;
            end else begin
                report_failure({"unknown op code in the stimulus file: ", op});
            end
            v.a          = 10'(a);
            v.b          = 10'(b);
            v.n          = 8'(n);
            v.cover_flag = cov[0];
            v.level      = level_t'(lvl);
            v.playing    = ply[0];
            v.p1         = player_t'(6'(e1));
            v.p2         = player_t'(6'(e2));
            v.addr       = pix_addr_t'(ea);
            vecs.push_back(v);
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input vec_t v);
        pix_coord_t rh;
        pix_coord_t rv;
        @(posedge clk);
        if (v.op == OP_KEY) begin
            key_down <= key_vec_t'(v.a);
        end else if (v.op == OP_PHYS) begin
            p1_phys <= phys_t'(v.a[2:0]);
            p2_phys <= phys_t'(v.b[2:0]);
        end else if (v.op == OP_PIX) begin
            vga_h <= v.a;
            vga_v <= v.b;
        end
        if (v.op == OP_PIX) begin
            @(posedge clk); // address is one cycle behind.
        end else begin
            repeat (v.n) @(posedge clk);
        end
        @(negedge clk);
        check_flag("flag_cover", flag_cover, v.cover_flag);
        check_level("level", level, v.level);
        check_flag("playing", playing, v.playing);
        check_player("p1", p1, v.p1);
        check_player("p2", p2, v.p2);
        check_addr("pixel_addr", pixel_addr, v.addr);
        if (v.op == OP_PIX && v.n != 0) begin
            for (int i = 0; i < int'(v.n); i++) begin
                rh = pix_coord_t'(280 + $urandom % 70); // mostly around the menu column.
                rv = pix_coord_t'(70 + $urandom % 410);
                @(posedge clk);
                vga_h <= rh;
                vga_v <= rv;
                @(posedge clk);
                @(negedge clk);
                check_addr("pixel_addr", pixel_addr,
                           expected_addr(rh, rv, v.level, v.playing, v.cover_flag));
            end
            @(posedge clk);
            vga_h <= v.a; // back to the vector's own coordinate.
            vga_v <= v.b;
            @(posedge clk);
        end
    endtask

    initial begin
        void'($urandom(20));
        rst      = 1'b1;
        key_down = '0;
        vga_h    = '0;
        vga_v    = '0;
        p1_phys  = '0;
        p2_phys  = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        foreach (vecs[i]) begin
            vec_idx = i;
            run_vector(vecs[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        int limit;
        wait (loaded);
        limit = vecs.size() * CYC_PER_VEC + CYC_MARGIN;
        repeat (limit) @(posedge clk);
        report_failure($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end

endmodule
